// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int REG_ADDR_W = 2;

    // opcodes.
    localparam logic [3:0] OP_ADI   = 4'd4;
    localparam logic [3:0] OP_ORI   = 4'd5;
    localparam logic [3:0] OP_LHI   = 4'd6;
    localparam logic [3:0] OP_LWD   = 4'd7;
    localparam logic [3:0] OP_SWD   = 4'd8;
    localparam logic [3:0] OP_RTYPE = 4'd15;

    // r-type function codes.
    localparam logic [5:0] FN_ADD = 6'd0;
    localparam logic [5:0] FN_SUB = 6'd1;
    localparam logic [5:0] FN_AND = 6'd2;
    localparam logic [5:0] FN_ORR = 6'd3;
    localparam logic [5:0] FN_NOT = 6'd4;
    localparam logic [5:0] FN_TCP = 6'd5;
    localparam logic [5:0] FN_SHL = 6'd6;
    localparam logic [5:0] FN_SHR = 6'd7;
    localparam logic [5:0] FN_WWD = 6'd28;
    localparam logic [5:0] FN_HLT = 6'd29;

    // one instruction word, two field layouts.
    typedef union packed {
        struct packed {
            logic [3:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [5:0]            func;
        } r;
        struct packed {
            logic [3:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [7:0]            imm;
        } i;
    } instr_word_t;

endpackage

// File: rtl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_NOT = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_TCP = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SHL = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SHR = 3'd7;

    // source of the value written back.
    localparam logic WB_ALU = 1'b0;
    localparam logic WB_MEM = 1'b1;

endpackage

// File: rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
    parameter int WORD_SIZE = 16
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [WORD_SIZE-1:0]               rs_data,
    output logic [WORD_SIZE-1:0]               rt_data,
    input  logic                               wb_en,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [WORD_SIZE-1:0]               wb_data
);
    import cpu_isa_pkg::*;

    logic [WORD_SIZE-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write-through covers the producer two instructions ahead.
    assign rs_data = (wb_en && wb_addr == rs_addr) ? wb_data : regs[rs_addr];
    assign rt_data = (wb_en && wb_addr == rt_addr) ? wb_data : regs[rt_addr];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
    parameter int WORD_SIZE = 16
) (
    input  logic                               instr_valid,
    input  cpu_isa_pkg::instr_word_t           instr,
    input  logic                               halted,
    input  logic [WORD_SIZE-1:0]               rf_rs_data,
    input  logic [WORD_SIZE-1:0]               rf_rt_data,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rs,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rt,
    output logic                               valid,
    output logic [WORD_SIZE-1:0]               rs_data,
    output logic [WORD_SIZE-1:0]               rt_data,
    output logic [WORD_SIZE-1:0]               imm_ext,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rd,
    output logic [cpu_ctrl_pkg::ALU_OP_W-1:0]  alu_op,
    output logic                               alu_src_imm,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               reg_write,
    output logic                               wb_src,
    output logic                               is_wwd,
    output logic                               is_hlt
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic                 legal;
    logic [WORD_SIZE-1:0] imm_sext;
    logic [WORD_SIZE-1:0] imm_zext;

    assign rs       = instr.i.rs;
    assign rt       = instr.i.rt;
    assign rs_data  = rf_rs_data;
    assign rt_data  = rf_rt_data;
    assign imm_sext = {{(WORD_SIZE-8){instr.i.imm[7]}}, instr.i.imm};
    assign imm_zext = {{(WORD_SIZE-8){1'b0}}, instr.i.imm};

    always_comb begin
        legal       = 1'b1;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        wb_src      = WB_ALU;
        is_wwd      = 1'b0;
        is_hlt      = 1'b0;
        imm_ext     = '0;
        rd          = instr.i.rt;
        case (instr.i.opcode)
            OP_ADI: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                imm_ext     = imm_sext;
            end
            OP_ORI: begin
                alu_op      = ALU_OR;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                imm_ext     = imm_zext;
            end
            OP_LHI: begin
                // immediate and, which the alu reads as pass the immediate.
                alu_op      = ALU_AND;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                imm_ext     = imm_zext << 8;
            end
            OP_LWD: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                wb_src    = WB_MEM;
                imm_ext   = imm_sext;
            end
            OP_SWD: begin
                mem_write = 1'b1;
                imm_ext   = imm_sext;
            end
            OP_RTYPE: begin
                rd        = instr.r.rd;
                reg_write = 1'b1;
                case (instr.r.func)
                    FN_ADD: alu_op = ALU_ADD;
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_ORR: alu_op = ALU_OR;
                    FN_NOT: alu_op = ALU_NOT;
                    FN_TCP: alu_op = ALU_TCP;
                    FN_SHL: alu_op = ALU_SHL;
                    FN_SHR: alu_op = ALU_SHR;
                    FN_WWD: begin
                        // rs plus a zero immediate.
                        reg_write   = 1'b0;
                        alu_src_imm = 1'b1;
                        is_wwd      = 1'b1;
                    end
                    FN_HLT: begin
                        reg_write = 1'b0;
                        is_hlt    = 1'b1;
                    end
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase

        valid = instr_valid && !halted && legal;
        if (!valid) begin
            alu_op      = ALU_ADD;
            alu_src_imm = 1'b0;
            mem_read    = 1'b0;
            mem_write   = 1'b0;
            reg_write   = 1'b0;
            wb_src      = WB_ALU;
            is_wwd      = 1'b0;
            is_hlt      = 1'b0;
        end
    end

endmodule

// File: rtl/id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg #(
    parameter int WORD_SIZE = 16
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               valid,
    input  logic [WORD_SIZE-1:0]               rs_data,
    input  logic [WORD_SIZE-1:0]               rt_data,
    input  logic [WORD_SIZE-1:0]               imm_ext,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] rs,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] rt,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] rd,
    input  logic [cpu_ctrl_pkg::ALU_OP_W-1:0]  alu_op,
    input  logic                               alu_src_imm,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic                               reg_write,
    input  logic                               wb_src,
    input  logic                               is_wwd,
    input  logic                               is_hlt,
    output logic                               ex_valid,
    output logic [WORD_SIZE-1:0]               ex_rs_data,
    output logic [WORD_SIZE-1:0]               ex_rt_data,
    output logic [WORD_SIZE-1:0]               ex_imm_ext,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rs,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rt,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [cpu_ctrl_pkg::ALU_OP_W-1:0]  ex_alu_op,
    output logic                               ex_alu_src_imm,
    output logic                               ex_mem_read,
    output logic                               ex_mem_write,
    output logic                               ex_reg_write,
    output logic                               ex_wb_src,
    output logic                               ex_is_wwd,
    output logic                               ex_is_hlt
);
    import cpu_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_valid       <= 1'b0;
            ex_alu_op      <= ALU_ADD;
            ex_alu_src_imm <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_wb_src      <= WB_ALU;
            ex_is_wwd      <= 1'b0;
            ex_is_hlt      <= 1'b0;
        end else begin
            ex_valid       <= valid;
            ex_alu_op      <= alu_op;
            ex_alu_src_imm <= alu_src_imm;
            // a bubble must not write or touch memory.
            ex_mem_read    <= valid && mem_read;
            ex_mem_write   <= valid && mem_write;
            ex_reg_write   <= valid && reg_write;
            ex_wb_src      <= wb_src;
            ex_is_wwd      <= valid && is_wwd;
            ex_is_hlt      <= valid && is_hlt;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs_data <= rs_data;
        ex_rt_data <= rt_data;
        ex_imm_ext <= imm_ext;
        ex_rs      <= rs;
        ex_rt      <= rt;
        ex_rd      <= rd;
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage #(
    parameter int WORD_SIZE  = 16,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               ex_valid,
    input  logic [WORD_SIZE-1:0]               ex_rs_data,
    input  logic [WORD_SIZE-1:0]               ex_rt_data,
    input  logic [WORD_SIZE-1:0]               ex_imm_ext,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rs,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rt,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [cpu_ctrl_pkg::ALU_OP_W-1:0]  ex_alu_op,
    input  logic                               ex_alu_src_imm,
    input  logic                               ex_mem_read,
    input  logic                               ex_mem_write,
    input  logic                               ex_reg_write,
    input  logic                               ex_wb_src,
    input  logic                               ex_is_wwd,
    input  logic                               ex_is_hlt,
    input  logic                               fwd_en,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] fwd_addr,
    input  logic [WORD_SIZE-1:0]               fwd_data,
    output logic [WORD_SIZE-1:0]               result,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] dest,
    output logic                               reg_write,
    output logic                               is_wwd,
    output logic                               is_hlt,
    output logic                               valid
);
    import cpu_ctrl_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [WORD_SIZE-1:0] dmem [DMEM_DEPTH];
    logic [WORD_SIZE-1:0] op_a;
    logic [WORD_SIZE-1:0] rt_val;
    logic [WORD_SIZE-1:0] op_b;
    logic [WORD_SIZE-1:0] alu_res;
    logic [WORD_SIZE-1:0] addr_sum;
    logic [DMEM_AW-1:0]   mem_addr;
    logic [WORD_SIZE-1:0] mem_rdata;

    // the instruction just ahead sits in the writeback register.
    assign op_a   = (fwd_en && fwd_addr == ex_rs) ? fwd_data : ex_rs_data;
    assign rt_val = (fwd_en && fwd_addr == ex_rt) ? fwd_data : ex_rt_data;
    assign op_b   = ex_alu_src_imm ? ex_imm_ext : rt_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = ex_alu_src_imm ? op_b : (op_a & op_b);
            ALU_OR:  alu_res = op_a | op_b;
            ALU_NOT: alu_res = ~op_a;
            ALU_TCP: alu_res = ~op_a + 1'b1;
            ALU_SHL: alu_res = {op_a[WORD_SIZE-2:0], 1'b0};
            ALU_SHR: alu_res = {op_a[WORD_SIZE-1], op_a[WORD_SIZE-1:1]};
            default: alu_res = '0;
        endcase
    end

    // address wraps at the memory size.
    assign addr_sum  = op_a + ex_imm_ext;
    assign mem_addr  = addr_sum[DMEM_AW-1:0];
    assign mem_rdata = ex_mem_read ? dmem[mem_addr] : '0;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_write) begin
            dmem[mem_addr] <= rt_val;
        end
    end

    assign result    = (ex_wb_src == WB_MEM) ? mem_rdata : alu_res;
    assign dest      = ex_rd;
    assign reg_write = ex_reg_write;
    assign is_wwd    = ex_is_wwd;
    assign is_hlt    = ex_is_hlt;
    assign valid     = ex_valid;

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage #(
    parameter int WORD_SIZE = 16
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               valid,
    input  logic [WORD_SIZE-1:0]               result,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] dest,
    input  logic                               reg_write,
    input  logic                               is_wwd,
    input  logic                               is_hlt,
    output logic                               wb_en,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [WORD_SIZE-1:0]               wb_data,
    output logic                               wwd_valid,
    output logic [WORD_SIZE-1:0]               wwd_data,
    output logic                               halted
);
    logic valid_q;
    logic reg_write_q;
    logic is_wwd_q;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
            is_wwd_q    <= 1'b0;
            halted      <= 1'b0;
        end else begin
            valid_q     <= valid;
            reg_write_q <= reg_write;
            is_wwd_q    <= is_wwd;
            // sticky until the next reset.
            if (valid && is_hlt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= dest;
        wb_data <= result;
    end

    assign wb_en     = valid_q && reg_write_q;
    assign wwd_valid = valid_q && is_wwd_q;
    assign wwd_data  = wb_data;

endmodule

// File: rtl/cpu_core_top.sv
`timescale 1ns/100ps

module cpu_core_top #(
    parameter int WORD_SIZE  = 16,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     instr_valid,
    input  cpu_isa_pkg::instr_word_t instr,
    output logic                     wwd_valid,
    output logic [WORD_SIZE-1:0]     wwd_data,
    output logic                     halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [WORD_SIZE-1:0]  rf_rs_data, rf_rt_data;

    logic                  id_valid, id_alu_src_imm, id_mem_read, id_mem_write;
    logic                  id_reg_write, id_wb_src, id_is_wwd, id_is_hlt;
    logic [WORD_SIZE-1:0]  id_rs_data, id_rt_data, id_imm_ext;
    logic [REG_ADDR_W-1:0] id_rs, id_rt, id_rd;
    logic [ALU_OP_W-1:0]   id_alu_op;

    logic                  ex_valid, ex_alu_src_imm, ex_mem_read, ex_mem_write;
    logic                  ex_reg_write, ex_wb_src, ex_is_wwd, ex_is_hlt;
    logic [WORD_SIZE-1:0]  ex_rs_data, ex_rt_data, ex_imm_ext;
    logic [REG_ADDR_W-1:0] ex_rs, ex_rt, ex_rd;
    logic [ALU_OP_W-1:0]   ex_alu_op;

    logic                  res_valid, res_reg_write, res_is_wwd, res_is_hlt;
    logic [WORD_SIZE-1:0]  res_data;
    logic [REG_ADDR_W-1:0] res_dest;

    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [WORD_SIZE-1:0]  wb_data;

    reg_file #(.WORD_SIZE(WORD_SIZE)) u_reg_file (
        .clk(clk), .reset_n(reset_n),
        .rs_addr(id_rs), .rt_addr(id_rt),
        .rs_data(rf_rs_data), .rt_data(rf_rt_data),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    decode_stage #(.WORD_SIZE(WORD_SIZE)) u_decode (
        .instr_valid(instr_valid), .instr(instr), .halted(halted),
        .rf_rs_data(rf_rs_data), .rf_rt_data(rf_rt_data),
        .rs(id_rs), .rt(id_rt), .valid(id_valid),
        .rs_data(id_rs_data), .rt_data(id_rt_data), .imm_ext(id_imm_ext), .rd(id_rd),
        .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm),
        .mem_read(id_mem_read), .mem_write(id_mem_write),
        .reg_write(id_reg_write), .wb_src(id_wb_src),
        .is_wwd(id_is_wwd), .is_hlt(id_is_hlt)
    );

    id_ex_reg #(.WORD_SIZE(WORD_SIZE)) u_id_ex (
        .clk(clk), .reset_n(reset_n), .valid(id_valid),
        .rs_data(id_rs_data), .rt_data(id_rt_data), .imm_ext(id_imm_ext),
        .rs(id_rs), .rt(id_rt), .rd(id_rd),
        .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm),
        .mem_read(id_mem_read), .mem_write(id_mem_write),
        .reg_write(id_reg_write), .wb_src(id_wb_src),
        .is_wwd(id_is_wwd), .is_hlt(id_is_hlt),
        .ex_valid(ex_valid),
        .ex_rs_data(ex_rs_data), .ex_rt_data(ex_rt_data), .ex_imm_ext(ex_imm_ext),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_wb_src(ex_wb_src),
        .ex_is_wwd(ex_is_wwd), .ex_is_hlt(ex_is_hlt)
    );

    execute_stage #(.WORD_SIZE(WORD_SIZE), .DMEM_DEPTH(DMEM_DEPTH)) u_execute (
        .clk(clk), .reset_n(reset_n), .ex_valid(ex_valid),
        .ex_rs_data(ex_rs_data), .ex_rt_data(ex_rt_data), .ex_imm_ext(ex_imm_ext),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_wb_src(ex_wb_src),
        .ex_is_wwd(ex_is_wwd), .ex_is_hlt(ex_is_hlt),
        .fwd_en(wb_en), .fwd_addr(wb_addr), .fwd_data(wb_data),
        .result(res_data), .dest(res_dest), .reg_write(res_reg_write),
        .is_wwd(res_is_wwd), .is_hlt(res_is_hlt), .valid(res_valid)
    );

    writeback_stage #(.WORD_SIZE(WORD_SIZE)) u_writeback (
        .clk(clk), .reset_n(reset_n), .valid(res_valid),
        .result(res_data), .dest(res_dest), .reg_write(res_reg_write),
        .is_wwd(res_is_wwd), .is_hlt(res_is_hlt),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .wwd_valid(wwd_valid), .wwd_data(wwd_data), .halted(halted)
    );

endmodule

// File: dv/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb;
    import cpu_isa_pkg::*;

    localparam int          WORD_SIZE  = 16;
    localparam int          DMEM_DEPTH = 16;
    localparam int          CLK_PERIOD = 10;
    localparam logic [31:0] SEED       = 32'h8cc4_dfd9;
    localparam int          N_ALU      = 130;
    localparam int          N_MEM      = 70;
    localparam int          N_LAT      = 40;
    localparam int          MAX_IDLE   = 3;
    localparam int          DRAIN_MAX  = 8;
    // memory and bubble steps issue up to two instructions.
    localparam int MAX_INSTR       = 4 + N_ALU + 2 * N_MEM + 2 * N_LAT + 3;
    localparam int WATCHDOG_CYCLES = MAX_INSTR * (1 + MAX_IDLE) + 5 * (DRAIN_MAX + 2) + 10 + 50;

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 instr_valid;
    instr_word_t          instr;
    logic                 wwd_valid;
    logic [WORD_SIZE-1:0] wwd_data;
    logic                 halted;

    // reference model state.
    logic [WORD_SIZE-1:0] m_regs [4];
    logic [WORD_SIZE-1:0] m_mem [DMEM_DEPTH];
    logic                 m_halted;
    int                   halt_edge;
    logic [WORD_SIZE-1:0] exp_val_q [$];
    int                   exp_cyc_q [$];
    logic [WORD_SIZE-1:0] exp_val;
    int                   exp_cyc;

    int    cyc = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    string cur_test = "startup";

    cpu_core_top #(.WORD_SIZE(WORD_SIZE), .DMEM_DEPTH(DMEM_DEPTH)) dut (
        .clk(clk), .reset_n(reset_n), .instr_valid(instr_valid), .instr(instr),
        .wwd_valid(wwd_valid), .wwd_data(wwd_data), .halted(halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] r_word(input logic [5:0] fn, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [1:0] rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] i_word(input logic [3:0] op, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // executes one accepted instruction in program order.
    task automatic model_exec(input logic [15:0] w, input int accept);
        logic [1:0]           rs;
        logic [1:0]           rt;
        logic [1:0]           rd;
        logic [7:0]           imm;
        logic [WORD_SIZE-1:0] a;
        logic [WORD_SIZE-1:0] b;
        logic [WORD_SIZE-1:0] sx;
        logic [WORD_SIZE-1:0] zx;
        logic [WORD_SIZE-1:0] addr_sum;
        int                   addr;
        rs       = w[11:10];
        rt       = w[9:8];
        rd       = w[7:6];
        imm      = w[7:0];
        a        = m_regs[rs];
        b        = m_regs[rt];
        sx       = {{(WORD_SIZE-8){imm[7]}}, imm};
        zx       = {{(WORD_SIZE-8){1'b0}}, imm};
        addr_sum = a + sx;
        addr     = int'(addr_sum) % DMEM_DEPTH;
        case (w[15:12])
            OP_ADI: m_regs[rt] = a + sx;
            OP_ORI: m_regs[rt] = a | zx;
            OP_LHI: m_regs[rt] = zx << 8;
            OP_LWD: m_regs[rt] = m_mem[addr];
            OP_SWD: m_mem[addr] = b;
            OP_RTYPE: begin
                case (w[5:0])
                    FN_ADD: m_regs[rd] = a + b;
                    FN_SUB: m_regs[rd] = a - b;
                    FN_AND: m_regs[rd] = a & b;
                    FN_ORR: m_regs[rd] = a | b;
                    FN_NOT: m_regs[rd] = ~a;
                    FN_TCP: m_regs[rd] = '0 - a;
                    FN_SHL: m_regs[rd] = a << 1;
                    FN_SHR: m_regs[rd] = $signed(a) >>> 1;
                    FN_WWD: begin
                        exp_val_q.push_back(a);
                        exp_cyc_q.push_back(accept + 1);
                    end
                    FN_HLT: begin
                        m_halted  = 1'b1;
                        halt_edge = accept;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    endtask

    task automatic issue_instr(input logic [15:0] w);
        int accept;
        accept      = cyc + 1;
        instr_valid = 1'b1;
        instr       = w;
        // only the instruction right behind an hlt still gets in.
        if (!m_halted || accept <= halt_edge + 1) begin
            model_exec(w, accept);
        end
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            instr_valid = 1'b0;
            instr       = 16'($urandom);
            @(negedge clk);
        end
    endtask

    task automatic maybe_idle();
        if ($urandom_range(3, 0) == 0) begin
            idle_cycles($urandom_range(MAX_IDLE, 1));
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited      = 0;
        instr_valid = 1'b0;
        while (exp_val_q.size() != 0 && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited++;
        end
        // two more cycles so that stray outputs show up.
        repeat (2) @(negedge clk);
        if (exp_val_q.size() != 0) begin
            $display("ERROR %s: %0d expected WWD outputs never appeared",
                     cur_test, exp_val_q.size());
            errors++;
            exp_val_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s %s expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input int base);
        tests_run++;
        if (errors == base) begin
            $display("test %s: PASS", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d failed checks", cur_test, errors - base);
        end
    endtask

    // every wwd output is matched against the model queue.
    always @(negedge clk) begin
        if (reset_n == 1'b0 && wwd_valid === 1'b1) begin
            if (exp_val_q.size() == 0) begin
                $display("ERROR %s: WWD output %h at cycle %0d with none expected",
                         cur_test, wwd_data, cyc);
                errors++;
            end else begin
                exp_val = exp_val_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                if (wwd_data !== exp_val) begin
                    $display("MISMATCH %s wwd_data expected %h actual %h",
                             cur_test, exp_val, wwd_data);
                    errors++;
                end
                if (cyc != exp_cyc) begin
                    $display("MISMATCH %s wwd cycle expected %0d actual %0d",
                             cur_test, exp_cyc, cyc);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int         base;
        int         k;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        void'($urandom(SEED));
        reset_n     = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        m_halted    = 1'b0;
        halt_edge   = 0;
        for (int i = 0; i < 4; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;

        cur_test = "reset_state";
        base     = errors;
        check_bit("wwd_valid", 1'b0, wwd_valid);
        check_bit("halted", 1'b0, halted);
        for (int r = 0; r < 4; r++) begin
            issue_instr(r_word(FN_WWD, 2'(r), 2'd0, 2'd0));
        end
        drain_pipeline();
        finish_test(base);

        cur_test = "dependent_alu";
        base     = errors;
        for (int i = 0; i < N_ALU; i++) begin
            k  = $urandom_range(9, 0);
            rs = 2'($urandom);
            rt = 2'($urandom);
            rd = 2'($urandom);
            case (k)
                0, 1, 2, 3: issue_instr(r_word(6'($urandom_range(7, 0)), rs, rt, rd));
                4: issue_instr(i_word(OP_ADI, rs, rt, 8'($urandom)));
                5: issue_instr(i_word(OP_ORI, rs, rt, 8'($urandom)));
                6: issue_instr(i_word(OP_LHI, rs, rt, 8'($urandom)));
                default: issue_instr(r_word(FN_WWD, rs, 2'd0, 2'd0));
            endcase
            maybe_idle();
        end
        drain_pipeline();
        finish_test(base);

        cur_test = "memory";
        base     = errors;
        for (int i = 0; i < N_MEM; i++) begin
            k  = $urandom_range(9, 0);
            rs = 2'($urandom);
            rt = 2'($urandom);
            rd = 2'($urandom);
            case (k)
                0, 1, 2: issue_instr(i_word(OP_SWD, rs, rt, 8'($urandom)));
                3, 4, 5: begin
                    issue_instr(i_word(OP_LWD, rs, rt, 8'($urandom)));
                    // consumer right behind the load.
                    if ($urandom_range(1, 0) == 0) begin
                        issue_instr(r_word(FN_WWD, rt, 2'd0, 2'd0));
                    end else begin
                        issue_instr(i_word(OP_ADI, rt, rd, 8'($urandom)));
                    end
                end
                6, 7: issue_instr(i_word(OP_ADI, rs, rt, 8'($urandom)));
                default: issue_instr(r_word(FN_WWD, rs, 2'd0, 2'd0));
            endcase
            maybe_idle();
        end
        drain_pipeline();
        finish_test(base);

        cur_test = "latency_bubbles";
        base     = errors;
        for (int i = 0; i < N_LAT; i++) begin
            if ($urandom_range(4, 0) == 0) begin
                // unknown function code, decoded as a bubble.
                rs = 2'($urandom);
                rt = 2'($urandom);
                rd = 2'($urandom);
                issue_instr(r_word(6'($urandom_range(27, 8)), rs, rt, rd));
                issue_instr(r_word(FN_WWD, rd, 2'd0, 2'd0));
            end else begin
                issue_instr(r_word(FN_WWD, 2'($urandom), 2'd0, 2'd0));
            end
            idle_cycles($urandom_range(MAX_IDLE, 1));
        end
        drain_pipeline();
        finish_test(base);

        cur_test = "halt";
        base     = errors;
        issue_instr(r_word(FN_HLT, 2'd0, 2'd0, 2'd0));
        check_bit("halted at accept edge", 1'b0, halted);
        issue_instr(r_word(FN_WWD, 2'($urandom), 2'd0, 2'd0));
        check_bit("halted one edge after accept", 1'b1, halted);
        issue_instr(r_word(FN_WWD, 2'($urandom), 2'd0, 2'd0));
        drain_pipeline();
        check_bit("halted after drain", 1'b1, halted);
        finish_test(base);

        $display("tests %0d, failed %0d, failed checks %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/cpu_core_top.sv
dv/cpu_core_tb.sv

// File: Makefile
SIM := obj_dir/Vcpu_core_tb

.PHONY: all run clean

all: run

$(SIM): all.f $(shell cat all.f)
	verilator --binary --timing -Wno-fatal --top-module cpu_core_tb -f all.f -o Vcpu_core_tb

sim.log: $(SIM)
	./$(SIM) | tee sim.log

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^No errors$$' sim.log

clean:
	rm -rf obj_dir sim.log
